// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_ex_stage -f verilog.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "^NO ERRORS$" sim.log

// ==== sim/tb_rv_ex_stage.sv ====
// stimulus only; results are checked by the checker bound into rv_ex_stage
module tb_rv_ex_stage;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc;
  logic [63:0] i_rs1data;
  logic [63:0] i_rs2data;
  logic [63:0] i_csrrdata;
  logic        o_valid;
  logic [63:0] o_alu_result;
  logic [63:0] o_csr_result;
  logic        o_halt;
  logic        o_abort;
  int          cycles = 0;

  rv_ex_stage DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [2:0] f3, input logic [6:0] opc);
    return {f7, rs2, 5'($urandom), f3, 5'($urandom), opc};
  endfunction

  // one random encoding from the supported set
  function automatic logic [31:0] rand_inst();
    logic [2:0] f3;
    logic       alt;
    f3  = 3'($urandom);
    alt = 1'($urandom);
    case ($urandom_range(0, 9))
      0: return enc((f3 == 3'd0 || f3 == 3'd5) && alt ? 7'h20 : 7'h00, 5'($urandom), f3, 7'h33);
      1: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          return enc({1'b0, f3 == 3'd5 && alt, 4'd0, 1'($urandom)}, 5'($urandom), f3, 7'h13);
        end
        return enc(7'($urandom), 5'($urandom), f3, 7'h13);
      end
      2: begin
        f3 = f3[0] ? 3'd5 : (f3[1] ? 3'd1 : 3'd0);
        return enc(f3 != 3'd1 && alt ? 7'h20 : 7'h00, 5'($urandom), f3, 7'h3b);
      end
      3: begin
        f3 = f3[0] ? 3'd5 : (f3[1] ? 3'd1 : 3'd0);
        if (f3 == 3'd0) return enc(7'($urandom), 5'($urandom), f3, 7'h1b);
        return enc(f3 == 3'd5 && alt ? 7'h20 : 7'h00, 5'($urandom), f3, 7'h1b);
      end
      4: return enc(7'($urandom), 5'($urandom), 3'($urandom), 7'h37);
      5: return enc(7'($urandom), 5'($urandom), 3'($urandom), 7'h17);
      6: return enc(7'($urandom), 5'($urandom), 3'($urandom), 7'h6f);
      7: return enc(7'($urandom), 5'($urandom), 3'd0, 7'h67);
      default: return enc(7'($urandom), 5'($urandom), {alt, f3[1:0] == 2'b00 ? 2'b01 : f3[1:0]},
                          7'h73);
    endcase
  endfunction

  task automatic issue(input logic [31:0] inst);
    @(posedge i_clk);
    i_valid    <= 1'b1;
    i_inst     <= inst;
    i_pc       <= rand64();
    i_rs1data  <= rand64();
    i_rs2data  <= rand64();
    i_csrrdata <= rand64();
  endtask

  // register-form shift with a fixed amount, upper rs2 bits random
  task automatic issue_reg_shift(input logic [31:0] inst, input logic [4:0] amt);
    issue(inst);
    i_rs2data <= {$urandom, 27'($urandom), amt};
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      i_valid    <= 1'b0;
      // inputs keep moving while idle, results must hold
      i_inst     <= $urandom;
      i_pc       <= rand64();
      i_rs1data  <= rand64();
      i_rs2data  <= rand64();
      i_csrrdata <= rand64();
    end
  endtask

  task automatic apply_reset();
    @(posedge i_clk);
    i_rst_n <= 1'b0;
    i_valid <= 1'b0;
    repeat (3) @(posedge i_clk);
    i_rst_n <= 1'b1;
  endtask

  // timeout and first failure
  always @(posedge i_clk) begin
    cycles++;
    if (DUT.u_chk.fail_cnt != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "checker assertion failed");
    end else if (cycles >= 1200) begin
      $display("ERRORS FOUND");
      $fatal(1, "timeout after %0d cycles", cycles);
    end
  end

  initial begin
    void'($urandom(32'h2b3b));
    i_rst_n    = 1'b0;
    i_valid    = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_rs1data  = '0;
    i_rs2data  = '0;
    i_csrrdata = '0;
    repeat (3) @(posedge i_clk);
    i_rst_n <= 1'b1;
    idle(2);
    // every integer form, full width
    for (int f = 0; f < 8; f++) begin
      issue(enc(7'h00, 5'($urandom), 3'(f), 7'h33));
      if (f == 1 || f == 5) begin
        issue(enc({6'd0, 1'($urandom)}, 5'($urandom), 3'(f), 7'h13));
      end else begin
        issue(enc(7'($urandom), 5'($urandom), 3'(f), 7'h13));
      end
    end
    issue(enc(7'h20, 5'($urandom), 3'd0, 7'h33));
    issue(enc(7'h20, 5'($urandom), 3'd5, 7'h33));
    issue(enc(7'h20, 5'($urandom), 3'd5, 7'h13));
    issue(enc(7'h20, 5'($urandom), 3'd0, 7'h3b));
    issue(enc(7'($urandom), 5'($urandom), 3'd0, 7'h1b));
    issue(enc(7'($urandom), 5'($urandom), 3'd0, 7'h37));
    issue(enc(7'($urandom), 5'($urandom), 3'd0, 7'h17));
    issue(enc(7'($urandom), 5'($urandom), 3'd0, 7'h6f));
    issue(enc(7'($urandom), 5'($urandom), 3'd0, 7'h67));
    for (int f = 1; f < 8; f++) begin
      if (f != 4) issue(enc(7'($urandom), 5'($urandom), 3'(f), 7'h73));
    end
    // word shifts at every amount
    for (int s = 0; s < 32; s++) begin
      issue(enc(7'h00, 5'(s), 3'd1, 7'h1b));
      issue(enc(7'h00, 5'(s), 3'd5, 7'h1b));
      issue(enc(7'h20, 5'(s), 3'd5, 7'h1b));
      issue_reg_shift(enc(7'h00, 5'($urandom), 3'd5, 7'h3b), 5'(s));
      issue_reg_shift(enc(7'h20, 5'($urandom), 3'd5, 7'h3b), 5'(s));
    end
    idle(2);
    for (int n = 0; n < 400; n++) begin
      issue(rand_inst());
      if ($urandom_range(0, 3) == 0) idle($urandom_range(1, 2));
    end
    idle(2);
    issue(32'h0000_0003);
    for (int n = 0; n < 5; n++) issue(rand_inst());
    idle(2);
    apply_reset();
    issue(32'h0010_0073);
    for (int n = 0; n < 5; n++) issue(rand_inst());
    idle(3);
    @(negedge i_clk);
    if (DUT.u_chk.fail_cnt != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "checker assertion failed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== sim/tb_rv_ex_stage_assert.sv ====
// checker bound into rv_ex_stage; result checks skip instructions that abort or halt
module tb_rv_ex_stage_assert (
  input logic        i_clk,
  input logic        i_rst_n,
  input logic        i_valid,
  input logic [31:0] i_inst,
  input logic [63:0] i_pc,
  input logic [63:0] i_rs1data,
  input logic [63:0] i_rs2data,
  input logic [63:0] i_csrrdata,
  input logic        o_valid,
  input logic [63:0] o_alu_result,
  input logic [63:0] o_csr_result,
  input logic        o_halt,
  input logic        o_abort
);
  import rv_exu_pkg::*;

  int          fail_cnt = 0;
  logic [63:0] ref_alu;
  logic [63:0] ref_csr;
  logic        ref_inv;
  logic        ref_ebk;
  logic [63:0] exp_alu_q;
  logic [63:0] exp_csr_q;
  logic        acc;
  logic        acc_q;
  logic        chk_q;
  logic        halt_q;
  logic        abort_q;

  // integer op by funct3, word ops cut both operands first
  function automatic logic [63:0] int_op(input logic [2:0] f3, input logic alt,
                                         input logic word, input logic [63:0] a_in,
                                         input logic [63:0] b_in);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [5:0]  sh;
    a  = word ? {32'd0, a_in[31:0]} : a_in;
    b  = word ? {32'd0, b_in[31:0]} : b_in;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = {63'd0, $signed(a) < $signed(b)};
      3'd3: r = {63'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (word) begin
          r = alt ? {32'd0, 32'($signed(a[31:0]) >>> sh[4:0])} : {32'd0, a[31:0] >> sh[4:0]};
        end else begin
          r = alt ? 64'($signed(a) >>> sh) : a >> sh;
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return word ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  always_comb begin
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] src;
    f3      = i_inst[14:12];
    f7      = i_inst[31:25];
    imm_i   = {{52{i_inst[31]}}, i_inst[31:20]};
    imm_u   = {{32{i_inst[31]}}, i_inst[31:12], 12'd0};
    src     = f3[2] ? {59'd0, i_inst[19:15]} : i_rs1data;
    ref_alu = '0;
    ref_csr = i_csrrdata;
    ref_inv = 1'b0;
    ref_ebk = 1'b0;
    case (i_inst[6:0])
      OPC_OP: begin
        ref_alu = int_op(f3, f7 == 7'h20, 1'b0, i_rs1data, i_rs2data);
        ref_inv = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      end
      OPC_OP_IMM: begin
        ref_alu = int_op(f3, f3 == 3'd5 && i_inst[30], 1'b0, i_rs1data, imm_i);
        if (f3 == 3'd1) ref_inv = f7[6:1] != 6'h00;
        if (f3 == 3'd5) ref_inv = f7[6:1] != 6'h00 && f7[6:1] != 6'h10;
      end
      OPC_OP_32: begin
        ref_alu = int_op(f3, f7 == 7'h20, 1'b1, i_rs1data, i_rs2data);
        ref_inv = !(((f3 == 3'd0 || f3 == 3'd5) && (f7 == 7'h00 || f7 == 7'h20)) ||
                    (f3 == 3'd1 && f7 == 7'h00));
      end
      OPC_OP_IMM_32: begin
        ref_alu = int_op(f3, f3 == 3'd5 && f7 == 7'h20, 1'b1, i_rs1data, imm_i);
        ref_inv = !(f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'h00) ||
                    (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20)));
      end
      OPC_LUI:   ref_alu = imm_u;
      OPC_AUIPC: ref_alu = i_pc + imm_u;
      OPC_JAL:   ref_alu = i_pc + 64'd4;
      OPC_JALR: begin
        ref_alu = i_pc + 64'd4;
        ref_inv = f3 != 3'd0;
      end
      OPC_SYSTEM: begin
        if (i_inst == 32'h0010_0073) begin
          ref_ebk = 1'b1;
        end else if (f3 == 3'd0 || f3 == 3'd4) begin
          ref_inv = 1'b1;
        end else begin
          ref_alu = i_csrrdata;
          case (f3[1:0])
            2'b01:   ref_csr = src;
            2'b10:   ref_csr = i_csrrdata | src;
            default: ref_csr = i_csrrdata & ~src;
          endcase
        end
      end
      default: ref_inv = 1'b1;
    endcase
  end

  assign acc = i_valid && !halt_q && !abort_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      acc_q     <= 1'b0;
      chk_q     <= 1'b1;
      halt_q    <= 1'b0;
      abort_q   <= 1'b0;
      exp_alu_q <= '0;
      exp_csr_q <= '0;
    end else begin
      acc_q <= acc;
      if (acc) begin
        chk_q     <= !ref_inv && !ref_ebk;
        exp_alu_q <= ref_alu;
        exp_csr_q <= ref_csr;
        if (ref_ebk) halt_q <= 1'b1;
        if (ref_inv) abort_q <= 1'b1;
      end
    end
  end

  a_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid == acc_q)
    else begin
      $error("Error o_valid %h expected %h", $sampled(o_valid), $sampled(acc_q));
      fail_cnt++;
    end

  a_alu: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                          chk_q |-> o_alu_result == exp_alu_q)
    else begin
      $error("Error o_alu_result %h expected %h", $sampled(o_alu_result), $sampled(exp_alu_q));
      fail_cnt++;
    end

  a_csr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                          chk_q |-> o_csr_result == exp_csr_q)
    else begin
      $error("Error o_csr_result %h expected %h", $sampled(o_csr_result), $sampled(exp_csr_q));
      fail_cnt++;
    end

  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                           !acc |=> $stable(o_alu_result) && $stable(o_csr_result))
    else begin
      $error("results changed while no instruction was accepted");
      fail_cnt++;
    end

  a_halt: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_halt == halt_q)
    else begin
      $error("Error o_halt %h expected %h", $sampled(o_halt), $sampled(halt_q));
      fail_cnt++;
    end

  a_abort: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_abort == abort_q)
    else begin
      $error("Error o_abort %h expected %h", $sampled(o_abort), $sampled(abort_q));
      fail_cnt++;
    end

  a_stop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                           (o_halt || o_abort) |=> !o_valid)
    else begin
      $error("o_valid rose after the stage was halted or aborted");
      fail_cnt++;
    end

endmodule

bind rv_ex_stage tb_rv_ex_stage_assert u_chk (.*);

// ==== src/rv_alu.sv ====
// 64-bit integer ALU; word mode expects operands already cut to 32 bits and zero-extended
module rv_alu (
  input  logic [rv_exu_pkg::WORD_WD-1:0] i_src_a,
  input  logic [rv_exu_pkg::WORD_WD-1:0] i_src_b,
  input  rv_exu_pkg::rv_alu_op_e         i_alu_op,
  input  logic                           i_word_cut,
  output logic [rv_exu_pkg::WORD_WD-1:0] o_alu_result
);
  import rv_exu_pkg::*;

  logic [5:0]         shamt;
  logic [WORD_WD-1:0] sra_src;
  logic               lt_signed;
  logic               lt_unsigned;
  logic [WORD_WD-1:0] result;

  // 5-bit shift amount for word ops
  assign shamt = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];

  // sraw needs the sign of bit 31 shifted in
  assign sra_src = i_word_cut ? {{(WORD_WD-32){i_src_a[31]}}, i_src_a[31:0]} : i_src_a;

  assign lt_signed   = $signed(i_src_a) < $signed(i_src_b);
  assign lt_unsigned = i_src_a < i_src_b;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    result = i_src_a + i_src_b;
      ALU_SUB:    result = i_src_a - i_src_b;
      ALU_SLL:    result = i_src_a << shamt;
      ALU_SLT:    result = {{(WORD_WD-1){1'b0}}, lt_signed};
      ALU_SLTU:   result = {{(WORD_WD-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result = i_src_a ^ i_src_b;
      ALU_SRL:    result = i_src_a >> shamt;
      ALU_SRA:    result = $unsigned($signed(sra_src) >>> shamt);
      ALU_OR:     result = i_src_a | i_src_b;
      ALU_AND:    result = i_src_a & i_src_b;
      ALU_COPY_B: result = i_src_b;
      default:    result = '0;
    endcase
  end

  // word results are sign-extended from bit 31
  assign o_alu_result = i_word_cut ? {{(WORD_WD-32){result[31]}}, result[31:0]} : result;

endmodule

// ==== src/rv_csu.sv ====
// new CSR value for the Zicsr write, set and clear forms; no CSR address or privilege checks
module rv_csu (
  input  logic [rv_exu_pkg::WORD_WD-1:0] i_src,
  input  logic [rv_exu_pkg::CSR_WD-1:0]  i_csrrdata,
  input  rv_exu_pkg::rv_csr_op_e         i_csr_op,
  output logic [rv_exu_pkg::CSR_WD-1:0]  o_csr_result
);
  import rv_exu_pkg::*;

  logic [CSR_WD-1:0] src;

  assign src = CSR_WD'(i_src);

  always_comb begin
    case (i_csr_op)
      CSR_RW:  o_csr_result = src;
      CSR_RS:  o_csr_result = i_csrrdata | src;
      CSR_RC:  o_csr_result = i_csrrdata & ~src;
      // not a csr instruction, old value unchanged
      default: o_csr_result = i_csrrdata;
    endcase
  end

endmodule

// ==== src/rv_ex_stage.sv ====
// one-cycle execute stage with no stall; after EBREAK or an invalid instruction only reset restarts it
module rv_ex_stage (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_valid,
  input  logic [rv_exu_pkg::INST_WD-1:0] i_inst,
  input  logic [rv_exu_pkg::PC_WD-1:0]   i_pc,
  input  logic [rv_exu_pkg::GPR_WD-1:0]  i_rs1data,
  input  logic [rv_exu_pkg::GPR_WD-1:0]  i_rs2data,
  input  logic [rv_exu_pkg::CSR_WD-1:0]  i_csrrdata,
  output logic                           o_valid,
  output logic [rv_exu_pkg::WORD_WD-1:0] o_alu_result,
  output logic [rv_exu_pkg::CSR_WD-1:0]  o_csr_result,
  output logic                           o_halt,
  output logic                           o_abort
);
  import rv_exu_pkg::*;

  rv_inst_u           inst;
  rv_ctrl_t           ctrl;
  logic [WORD_WD-1:0] imm;
  rv_opnd_t           opnd;
  rv_res_t            res;
  rv_res_t            res_q;
  logic               accept;

  assign inst = i_inst;

  rv_idu u_idu (
    .i_inst (inst),
    .o_ctrl (ctrl),
    .o_imm  (imm)
  );

  assign opnd.rs1data  = i_rs1data;
  assign opnd.rs2data  = i_rs2data;
  assign opnd.pc       = i_pc;
  assign opnd.csrrdata = i_csrrdata;
  assign opnd.imm      = imm;

  rv_exu u_exu (
    .i_ctrl (ctrl),
    .i_opnd (opnd),
    .o_res  (res)
  );

  // nothing enters once halted or aborted
  assign accept = i_valid && !o_halt && !o_abort;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
      o_halt  <= 1'b0;
      o_abort <= 1'b0;
      res_q   <= '0;
    end else begin
      o_valid <= accept;
      if (accept) begin
        res_q <= res;
        // sticky until reset
        if (ctrl.ebreak) begin
          o_halt <= 1'b1;
        end
        if (ctrl.invalid) begin
          o_abort <= 1'b1;
        end
      end
    end
  end

  assign o_alu_result = res_q.alu_result;
  assign o_csr_result = res_q.csr_result;

endmodule

// ==== src/rv_exu.sv ====
// combinational execute unit; the CSR source is rs1 or the zimm that the decoder puts in imm
module rv_exu (
  input  rv_exu_pkg::rv_ctrl_t i_ctrl,
  input  rv_exu_pkg::rv_opnd_t i_opnd,
  output rv_exu_pkg::rv_res_t  o_res
);
  import rv_exu_pkg::*;

  logic [WORD_WD-1:0] rs1;
  logic [WORD_WD-1:0] rs2;
  logic [WORD_WD-1:0] imm;
  logic [WORD_WD-1:0] src_a;
  logic [WORD_WD-1:0] src_b;
  logic [WORD_WD-1:0] csr_src;

  // word cut, low half zero-extended
  assign rs1 = i_ctrl.word_cut ? {{(WORD_WD-32){1'b0}}, i_opnd.rs1data[31:0]} : i_opnd.rs1data;
  assign rs2 = i_ctrl.word_cut ? {{(WORD_WD-32){1'b0}}, i_opnd.rs2data[31:0]} : i_opnd.rs2data;
  assign imm = i_ctrl.word_cut ? {{(WORD_WD-32){1'b0}}, i_opnd.imm[31:0]} : i_opnd.imm;

  assign src_a = i_ctrl.src1_pc ? WORD_WD'(i_opnd.pc) : rs1;

  always_comb begin
    case (i_ctrl.src2_sel)
      SRC2_RS2:  src_b = rs2;
      SRC2_IMM:  src_b = imm;
      SRC2_FOUR: src_b = WORD_WD'(4);
      default:   src_b = WORD_WD'(i_opnd.csrrdata);
    endcase
  end

  assign csr_src = i_ctrl.csr_imm ? i_opnd.imm : i_opnd.rs1data;

  rv_alu u_alu (
    .i_src_a      (src_a),
    .i_src_b      (src_b),
    .i_alu_op     (i_ctrl.alu_op),
    .i_word_cut   (i_ctrl.word_cut),
    .o_alu_result (o_res.alu_result)
  );

  rv_csu u_csu (
    .i_src        (csr_src),
    .i_csrrdata   (i_opnd.csrrdata),
    .i_csr_op     (i_ctrl.csr_op),
    .o_csr_result (o_res.csr_result)
  );

endmodule

// ==== src/rv_exu_pkg.sv ====
// shared types for the RV64I execute stage; all widths are fixed at 64 except the 32-bit instruction
package rv_exu_pkg;

  localparam int WORD_WD = 64;
  localparam int PC_WD   = 64;
  localparam int GPR_WD  = 64;
  localparam int CSR_WD  = 64;
  localparam int INST_WD = 32;

  // major opcodes
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

  // funct3 of the integer groups
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // SYSTEM funct3 000 holds ECALL, EBREAK and the returns
  localparam logic [2:0] F3_PRIV = 3'b000;
  localparam logic [2:0] F3_HINV = 3'b100;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  localparam logic [INST_WD-1:0] INST_EBREAK = 32'h0010_0073;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  typedef struct packed {
    logic        imm_20;
    logic [9:0]  imm_10_1;
    logic        imm_11;
    logic [7:0]  imm_19_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_j_fmt_t;

  typedef struct packed {
    logic [11:0] csr_addr;
    logic [4:0]  zimm;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_csr_fmt_t;

  typedef union packed {
    rv_r_fmt_t   r_fmt;
    rv_i_fmt_t   i_fmt;
    rv_u_fmt_t   u_fmt;
    rv_j_fmt_t   j_fmt;
    rv_csr_fmt_t csr_fmt;
  } rv_inst_u;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_COPY_B
  } rv_alu_op_e;

  typedef enum logic [1:0] {
    SRC2_RS2,
    SRC2_IMM,
    SRC2_FOUR,
    SRC2_CSR
  } rv_src2_e;

  typedef enum logic [3:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } rv_csr_op_e;

  typedef struct packed {
    logic       src1_pc;
    rv_src2_e   src2_sel;
    rv_alu_op_e alu_op;
    logic       word_cut;
    rv_csr_op_e csr_op;
    logic       csr_imm;
    logic       ebreak;
    logic       invalid;
  } rv_ctrl_t;

  typedef struct packed {
    logic [GPR_WD-1:0]  rs1data;
    logic [GPR_WD-1:0]  rs2data;
    logic [PC_WD-1:0]   pc;
    logic [CSR_WD-1:0]  csrrdata;
    logic [WORD_WD-1:0] imm;
  } rv_opnd_t;

  typedef struct packed {
    logic [WORD_WD-1:0] alu_result;
    logic [CSR_WD-1:0]  csr_result;
  } rv_res_t;

endpackage

// ==== src/rv_idu.sv ====
// RV64I + Zicsr decoder; loads, stores, branches, ECALL, MRET and FENCE all decode as invalid
module rv_idu (
  input  rv_exu_pkg::rv_inst_u          i_inst,
  output rv_exu_pkg::rv_ctrl_t          o_ctrl,
  output logic [rv_exu_pkg::WORD_WD-1:0] o_imm
);
  import rv_exu_pkg::*;

  logic [WORD_WD-1:0] imm_i;
  logic [WORD_WD-1:0] imm_u;
  logic [WORD_WD-1:0] imm_j;
  logic [WORD_WD-1:0] imm_z;
  logic [2:0]         funct3;
  logic [6:0]         funct7;

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic rv_alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
    rv_alu_op_e op;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3 = i_inst.r_fmt.funct3;
  assign funct7 = i_inst.r_fmt.funct7;

  assign imm_i = {{(WORD_WD-12){i_inst.i_fmt.imm_11_0[11]}}, i_inst.i_fmt.imm_11_0};
  assign imm_u = {{(WORD_WD-32){i_inst.u_fmt.imm_31_12[19]}}, i_inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{(WORD_WD-21){i_inst.j_fmt.imm_20}}, i_inst.j_fmt.imm_20,
                  i_inst.j_fmt.imm_19_12, i_inst.j_fmt.imm_11, i_inst.j_fmt.imm_10_1, 1'b0};
  assign imm_z = {{(WORD_WD-5){1'b0}}, i_inst.csr_fmt.zimm};

  always_comb begin
    o_ctrl          = '0;
    o_ctrl.src2_sel = SRC2_RS2;
    o_ctrl.alu_op   = ALU_ADD;
    o_ctrl.csr_op   = CSR_NONE;
    o_imm           = imm_i;
    case (i_inst.r_fmt.opcode)
      OPC_OP: begin
        o_ctrl.alu_op  = f3_to_op(funct3, funct7 == F7_ALT);
        o_ctrl.invalid = !(funct7 == F7_BASE ||
                           (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)));
      end
      OPC_OP_32: begin
        o_ctrl.word_cut = 1'b1;
        o_ctrl.alu_op   = f3_to_op(funct3, funct7 == F7_ALT);
        o_ctrl.invalid  = !((funct3 == F3_ADD && (funct7 == F7_BASE || funct7 == F7_ALT)) ||
                            (funct3 == F3_SLL && funct7 == F7_BASE) ||
                            (funct3 == F3_SR && (funct7 == F7_BASE || funct7 == F7_ALT)));
      end
      OPC_OP_IMM: begin
        o_ctrl.src2_sel = SRC2_IMM;
        // bit 30 only means SRA for the right shift, elsewhere it is immediate
        o_ctrl.alu_op   = f3_to_op(funct3, funct3 == F3_SR && funct7[5]);
        // shifts carry a 6-bit shamt, funct6 above it
        if (funct3 == F3_SLL) begin
          o_ctrl.invalid = funct7[6:1] != 6'b000000;
        end else if (funct3 == F3_SR) begin
          o_ctrl.invalid = funct7[6:1] != 6'b000000 && funct7[6:1] != 6'b010000;
        end
      end
      OPC_OP_IMM_32: begin
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.word_cut = 1'b1;
        o_ctrl.alu_op   = f3_to_op(funct3, funct3 == F3_SR && funct7 == F7_ALT);
        o_ctrl.invalid  = !(funct3 == F3_ADD ||
                            (funct3 == F3_SLL && funct7 == F7_BASE) ||
                            (funct3 == F3_SR && (funct7 == F7_BASE || funct7 == F7_ALT)));
      end
      OPC_LUI: begin
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.alu_op   = ALU_COPY_B;
        o_imm           = imm_u;
      end
      OPC_AUIPC: begin
        o_ctrl.src1_pc  = 1'b1;
        o_ctrl.src2_sel = SRC2_IMM;
        o_imm           = imm_u;
      end
      OPC_JAL: begin
        // link value only, target is computed elsewhere
        o_ctrl.src1_pc  = 1'b1;
        o_ctrl.src2_sel = SRC2_FOUR;
        o_imm           = imm_j;
      end
      OPC_JALR: begin
        o_ctrl.src1_pc  = 1'b1;
        o_ctrl.src2_sel = SRC2_FOUR;
        o_ctrl.invalid  = funct3 != F3_ADD;
      end
      OPC_SYSTEM: begin
        if (funct3 == F3_PRIV) begin
          o_ctrl.ebreak  = i_inst == INST_EBREAK;
          o_ctrl.invalid = i_inst != INST_EBREAK;
        end else if (funct3 == F3_HINV) begin
          o_ctrl.invalid = 1'b1;
        end else begin
          // alu returns the old csr value
          o_ctrl.src2_sel = SRC2_CSR;
          o_ctrl.alu_op   = ALU_COPY_B;
          o_ctrl.csr_imm  = funct3[2];
          o_imm           = imm_z;
          case (funct3[1:0])
            2'b01:   o_ctrl.csr_op = CSR_RW;
            2'b10:   o_ctrl.csr_op = CSR_RS;
            default: o_ctrl.csr_op = CSR_RC;
          endcase
        end
      end
      default: o_ctrl.invalid = 1'b1;
    endcase
  end

endmodule

// ==== verilog.f ====
src/rv_exu_pkg.sv
src/rv_idu.sv
src/rv_alu.sv
src/rv_csu.sv
src/rv_exu.sv
src/rv_ex_stage.sv
sim/tb_rv_ex_stage_assert.sv
sim/tb_rv_ex_stage.sv
